// File: src/ifuPkg.sv
////////////////////////////////////////////////////////////////////////////
// shared widths, opcodes, stage bundles, nop and reset vector of the IFU
////////////////////////////////////////////////////////////////////////////

package ifuPkg;

  // datapath width, fixed to rv32
  localparam int Xlen = 32;
  localparam int InstrClassWidth = 5;

  typedef logic [Xlen-1:0]            xlenT;
  typedef logic [31:0]                instrT;
  typedef logic [InstrClassWidth-1:0] instrClassT;

  // addi x0, x0, 0
  localparam instrT NopInstr    = 32'h0000_0013;
  localparam xlenT  ResetVector = 32'h8000_0000;

  ////////////////////////////////////////////////////////////////////////////
  // base opcodes that the decompressor and class decode produce or test
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [6:0] OpLoad   = 7'b0000011;
  localparam logic [6:0] OpOpImm  = 7'b0010011;
  localparam logic [6:0] OpStore  = 7'b0100011;
  localparam logic [6:0] OpOp     = 7'b0110011;
  localparam logic [6:0] OpLui    = 7'b0110111;
  localparam logic [6:0] OpBranch = 7'b1100011;
  localparam logic [6:0] OpJalr   = 7'b1100111;
  localparam logic [6:0] OpJal    = 7'b1101111;

  ////////////////////////////////////////////////////////////////////////////
  // stage register contents
  ////////////////////////////////////////////////////////////////////////////

  // fetch to decode
  typedef struct packed {
    xlenT  pc;
    // pc+2 or pc+4 of this instruction
    xlenT  pcLink;
    // word as read, still possibly compressed
    instrT instrRaw;
  } fetchDecodeT;

  // decode to execute
  typedef struct packed {
    xlenT       pc;
    xlenT       pcLink;
    // always the 32-bit form
    instrT      instr;
    instrClassT instrClass;
  } decodeExecT;

endpackage

// File: src/fetchStage.sv
////////////////////////////////////////////////////////////////////////////
// program counter, next-pc select, pc+2/4 adder and fetch-decode register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetchStage import ifuPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        StallF,
  input  logic        StallD,
  input  logic        FlushD,
  // execute-stage redirect
  input  logic        PCSrcE,
  input  xlenT        PCTargetE,
  // trap or xret redirect from memory stage
  input  logic        RetM,
  input  logic        TrapM,
  input  xlenT        PrivilegedNextPCM,
  // combinational instruction read at PCF
  input  instrT       InstrInF,
  output xlenT        PCF,
  output fetchDecodeT fetchDecode
);

  logic            compressedF;
  logic            privilegedChangeF;
  logic [Xlen-3:0] pcPlusUpperF;
  xlenT            pcPlus2or4F;
  xlenT            pcNextRawF;
  xlenT            pcNextF;
  fetchDecodeT     fetchDecodeNext;

  ////////////////////////////////////////////////////////////////////////////
  // sequential pc
  ////////////////////////////////////////////////////////////////////////////

  // anything not ending in 11 is a 16-bit parcel
  assign compressedF = (InstrInF[1:0] != 2'b11);

  // one shared incrementer on the word part of the pc
  assign pcPlusUpperF = PCF[Xlen-1:2] + 1'b1;

  always_comb begin
    if (compressedF) begin
      // +2 crosses into the next word only from the upper halfword
      if (PCF[1]) begin
        pcPlus2or4F = {pcPlusUpperF, 2'b00};
      end else begin
        pcPlus2or4F = {PCF[Xlen-1:2], 2'b10};
      end
    end else begin
      // +4 keeps the halfword offset
      pcPlus2or4F = {pcPlusUpperF, PCF[1:0]};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // next-pc priority
  ////////////////////////////////////////////////////////////////////////////

  assign privilegedChangeF = RetM | TrapM;

  // trap/return beats the branch, branch beats fall-through
  always_comb begin
    if (privilegedChangeF) begin
      pcNextRawF = PrivilegedNextPCM;
    end else if (PCSrcE) begin
      pcNextRawF = PCTargetE;
    end else begin
      pcNextRawF = pcPlus2or4F;
    end
  end

  // instructions sit on halfword boundaries, drop bit 0
  assign pcNextF = {pcNextRawF[Xlen-1:1], 1'b0};

  always_ff @(posedge clk) begin
    if (reset) begin
      PCF <= ResetVector;
    end else if (~StallF) begin
      PCF <= pcNextF;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // fetch to decode register
  ////////////////////////////////////////////////////////////////////////////

  // a flush only replaces the instruction, pc fields move as usual
  always_comb begin
    fetchDecodeNext.pc       = PCF;
    fetchDecodeNext.pcLink   = pcPlus2or4F;
    fetchDecodeNext.instrRaw = FlushD ? NopInstr : InstrInF;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fetchDecode <= '{pc: '0, pcLink: '0, instrRaw: NopInstr};
    end else if (~StallD) begin
      fetchDecode <= fetchDecodeNext;
    end
  end

endmodule

// File: src/decompress.sv
////////////////////////////////////////////////////////////////////////////
// rv32c expander for the supported subset, illegal flag for the rest
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module decompress import ifuPkg::*; (
  input  instrT instrRaw,
  output instrT instr,
  output logic  illegalComp
);

  logic [15:0] c;
  logic [1:0]  quadrant;
  logic [2:0]  funct3;
  // full register fields
  logic [4:0]  rd;
  logic [4:0]  rs2;
  // three-bit fields map onto x8..x15
  logic [4:0]  rdp;
  logic [4:0]  rs1p;
  logic [4:0]  rs2p;
  // pre-shuffled immediates
  logic [11:0] immCi;
  logic [11:0] immLw;
  logic [19:0] immJal;
  logic [12:1] offB;

  assign c        = instrRaw[15:0];
  assign quadrant = c[1:0];
  assign funct3   = c[15:13];
  assign rd       = c[11:7];
  assign rs2      = c[6:2];
  assign rdp      = {2'b01, c[4:2]};
  assign rs1p     = {2'b01, c[9:7]};
  assign rs2p     = {2'b01, c[4:2]};

  // sign-extended 6-bit imm of addi/li
  assign immCi = {{6{c[12]}}, c[12], c[6:2]};

  // word offset of lw/sw, uimm[6:2] = {c5, c12:10, c6}
  assign immLw = {5'b0, c[5], c[12:10], c[6], 2'b00};

  // jal immediate field already in j-type bit order
  // imm[20|10:1|11|19:12], offset bits come from c[12|8|10:9|6|7|2|11|5:3]
  assign immJal = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                   c[12], {8{c[12]}}};

  // branch offset, c[12|6:5|2|11:10|4:3] is off[8|7:6|5|4:3|2:1]
  assign offB = {{5{c[12]}}, c[6:5], c[2], c[11:10], c[4:3]};

  always_comb begin
    // unsupported patterns fall through as nop + illegal
    instr       = NopInstr;
    illegalComp = 1'b1;
    if (quadrant == 2'b11) begin
      // already a 32-bit word
      instr       = instrRaw;
      illegalComp = 1'b0;
    end else begin
      case ({quadrant, funct3})
        // c.lw -> lw rd', uimm(rs1')
        5'b00_010: begin
          instr       = {immLw, rs1p, 3'b010, rdp, OpLoad};
          illegalComp = 1'b0;
        end
        // c.sw -> sw rs2', uimm(rs1')
        5'b00_110: begin
          instr       = {immLw[11:5], rs2p, rs1p, 3'b010, immLw[4:0], OpStore};
          illegalComp = 1'b0;
        end
        // c.addi and c.nop -> addi rd, rd, imm
        5'b01_000: begin
          instr       = {immCi, rd, 3'b000, rd, OpOpImm};
          illegalComp = 1'b0;
        end
        // c.jal -> jal x1, off
        5'b01_001: begin
          instr       = {immJal, 5'd1, OpJal};
          illegalComp = 1'b0;
        end
        // c.li -> addi rd, x0, imm
        5'b01_010: begin
          instr       = {immCi, 5'd0, 3'b000, rd, OpOpImm};
          illegalComp = 1'b0;
        end
        // c.lui -> lui rd, imm; rd=x2 is addi16sp and imm 0 is reserved
        5'b01_011: begin
          if (rd != 5'd2 && {c[12], c[6:2]} != 6'd0) begin
            instr       = {{14{c[12]}}, c[12], c[6:2], rd, OpLui};
            illegalComp = 1'b0;
          end
        end
        // c.j -> jal x0, off
        5'b01_101: begin
          instr       = {immJal, 5'd0, OpJal};
          illegalComp = 1'b0;
        end
        // c.beqz -> beq rs1', x0, off
        5'b01_110: begin
          instr       = {offB[12], offB[10:5], 5'd0, rs1p, 3'b000,
                         offB[4:1], offB[11], OpBranch};
          illegalComp = 1'b0;
        end
        // c.bnez -> bne rs1', x0, off
        5'b01_111: begin
          instr       = {offB[12], offB[10:5], 5'd0, rs1p, 3'b001,
                         offB[4:1], offB[11], OpBranch};
          illegalComp = 1'b0;
        end
        // jr / mv / jalr / add share one funct3
        5'b10_100: begin
          if (~c[12]) begin
            if (rs2 == 5'd0) begin
              // c.jr, rd field is rs1 and must not be x0
              if (rd != 5'd0) begin
                instr       = {12'd0, rd, 3'b000, 5'd0, OpJalr};
                illegalComp = 1'b0;
              end
            end else begin
              // c.mv -> add rd, x0, rs2
              instr       = {7'd0, rs2, 5'd0, 3'b000, rd, OpOp};
              illegalComp = 1'b0;
            end
          end else if (rs2 == 5'd0) begin
            // c.jalr, rd=0 would be c.ebreak
            if (rd != 5'd0) begin
              instr       = {12'd0, rd, 3'b000, 5'd1, OpJalr};
              illegalComp = 1'b0;
            end
          end else begin
            // c.add -> add rd, rd, rs2
            instr       = {7'd0, rs2, rd, 3'b000, rd, OpOp};
            illegalComp = 1'b0;
          end
        end
        default: begin
          instr       = NopInstr;
          illegalComp = 1'b1;
        end
      endcase
    end
  end

endmodule

// File: src/decodeStage.sv
////////////////////////////////////////////////////////////////////////////
// decode: expansion, illegal flag, branch class, decode-execute register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module decodeStage import ifuPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        StallE,
  input  logic        FlushE,
  input  logic        IllegalBaseInstrFaultD,
  input  fetchDecodeT fetchDecode,
  output xlenT        PCD,
  output instrT       InstrD,
  output logic        IllegalIEUInstrFaultD,
  output decodeExecT  decodeExec
);

  logic       illegalCompD;
  logic [6:0] opD;
  logic [4:0] rdD;
  logic [4:0] rs1D;
  logic       rdLinkD;
  logic       rs1LinkD;
  logic       isJalD;
  logic       isJalrD;
  instrClassT instrClassD;
  decodeExecT decodeExecNext;

  assign PCD = fetchDecode.pc;

  decompress decomp (
    .instrRaw    (fetchDecode.instrRaw),
    .instr       (InstrD),
    .illegalComp (illegalCompD)
  );

  // bad 32-bit word from outside or unsupported 16-bit one
  assign IllegalIEUInstrFaultD = IllegalBaseInstrFaultD | illegalCompD;

  ////////////////////////////////////////////////////////////////////////////
  // instruction class for a predictor
  ////////////////////////////////////////////////////////////////////////////

  assign opD  = InstrD[6:0];
  assign rdD  = InstrD[11:7];
  assign rs1D = InstrD[19:15];

  // x1 and x5 are the link registers
  assign rdLinkD  = (rdD == 5'd1) | (rdD == 5'd5);
  assign rs1LinkD = (rs1D == 5'd1) | (rs1D == 5'd5);
  assign isJalD   = (opD == OpJal);
  assign isJalrD  = (opD == OpJalr);

  // call
  assign instrClassD[4] = (isJalD | isJalrD) & rdLinkD;
  // return, a jalr x1,x1 counts as both call and return
  assign instrClassD[3] = isJalrD & rs1LinkD;
  // plain indirect jump
  assign instrClassD[2] = isJalrD & ~rs1LinkD & ~rdLinkD;
  // plain direct jump
  assign instrClassD[1] = isJalD & ~rdLinkD;
  // conditional branch
  assign instrClassD[0] = (opD == OpBranch);

  ////////////////////////////////////////////////////////////////////////////
  // decode to execute register
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    decodeExecNext.pc         = fetchDecode.pc;
    decodeExecNext.pcLink     = fetchDecode.pcLink;
    // flushed slot becomes a nop with no class
    decodeExecNext.instr      = FlushE ? NopInstr : InstrD;
    decodeExecNext.instrClass = FlushE ? '0 : instrClassD;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      decodeExec <= '{pc: '0, pcLink: '0, instr: NopInstr, instrClass: '0};
    end else if (~StallE) begin
      decodeExec <= decodeExecNext;
    end
  end

endmodule

// File: src/executePipe.sv
////////////////////////////////////////////////////////////////////////////
// execute outputs, memory register and misaligned branch target fault
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module executePipe import ifuPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       StallM,
  input  logic       FlushM,
  input  logic       PCSrcE,
  input  xlenT       PCTargetE,
  input  decodeExecT decodeExec,
  output xlenT       PCE,
  output xlenT       PCLinkE,
  output instrT      InstrE,
  output xlenT       PCM,
  output instrT      InstrM,
  output instrClassT InstrClassM,
  output logic       InstrMisalignedFaultM,
  output xlenT       InstrMisalignedAdrM
);

  instrClassT instrClassE;
  logic       branchMisalignedE;

  // execute stage is just the register contents
  assign PCE         = decodeExec.pc;
  assign PCLinkE     = decodeExec.pcLink;
  assign InstrE      = decodeExec.instr;
  assign instrClassE = decodeExec.instrClass;

  ////////////////////////////////////////////////////////////////////////////
  // memory stage register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      PCM         <= '0;
      InstrM      <= NopInstr;
      InstrClassM <= '0;
    end else if (~StallM) begin
      PCM         <= PCE;
      // flush kills the instruction and its class
      InstrM      <= FlushM ? NopInstr : InstrE;
      InstrClassM <= FlushM ? '0 : instrClassE;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // misaligned target
  ////////////////////////////////////////////////////////////////////////////

  // with c enabled only an odd target is misaligned
  assign branchMisalignedE = PCSrcE & PCTargetE[0];

  always_ff @(posedge clk) begin
    if (reset) begin
      InstrMisalignedFaultM <= 1'b0;
    end else if (~StallM) begin
      InstrMisalignedFaultM <= branchMisalignedE;
    end
  end

  // the raw target, bit 0 still set, for the trap value
  always_ff @(posedge clk) begin
    if (~StallM) begin
      InstrMisalignedAdrM <= PCTargetE;
    end
  end

endmodule

// File: src/ifu.sv
////////////////////////////////////////////////////////////////////////////
// instruction fetch unit top, fetch -> decode -> execute/memory
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ifu import ifuPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       StallF,
  input  logic       StallD,
  input  logic       StallE,
  input  logic       StallM,
  input  logic       FlushD,
  input  logic       FlushE,
  input  logic       FlushM,
  // fetch
  input  instrT      InstrInF,
  output xlenT       PCF,
  // decode
  output xlenT       PCD,
  output instrT      InstrD,
  // execute
  output xlenT       PCE,
  output xlenT       PCLinkE,
  output instrT      InstrE,
  input  logic       PCSrcE,
  input  xlenT       PCTargetE,
  // memory
  input  logic       RetM,
  input  logic       TrapM,
  input  xlenT       PrivilegedNextPCM,
  output xlenT       PCM,
  output instrT      InstrM,
  output instrClassT InstrClassM,
  // faults
  input  logic       IllegalBaseInstrFaultD,
  output logic       IllegalIEUInstrFaultD,
  output logic       InstrMisalignedFaultM,
  output xlenT       InstrMisalignedAdrM
);

  fetchDecodeT fetchDecode;
  decodeExecT  decodeExec;

  fetchStage fetch0 (
    .clk, .reset, .StallF, .StallD, .FlushD, .PCSrcE, .PCTargetE,
    .RetM, .TrapM, .PrivilegedNextPCM, .InstrInF, .PCF, .fetchDecode
  );

  decodeStage decode0 (
    .clk, .reset, .StallE, .FlushE, .IllegalBaseInstrFaultD, .fetchDecode,
    .PCD, .InstrD, .IllegalIEUInstrFaultD, .decodeExec
  );

  executePipe execute0 (
    .clk, .reset, .StallM, .FlushM, .PCSrcE, .PCTargetE, .decodeExec,
    .PCE, .PCLinkE, .InstrE, .PCM, .InstrM, .InstrClassM,
    .InstrMisalignedFaultM, .InstrMisalignedAdrM
  );

endmodule

// File: dv/ifuTb.sv
////////////////////////////////////////////////////////////////////////////
// ifu testbench: clock, reset, halfword memory, checks and directed tests
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ifuTb import ifuPkg::*; ();

  localparam int ClkPeriod = 8;
  localparam int ResetCycles = 10;
  // test length is a few hundred cycles, the rest is margin
  localparam int WatchdogCycles = 2000;
  // expected values written out by hand
  localparam logic [31:0] ExpNop = 32'h0000_0013;
  localparam logic [31:0] ExpResetPc = 32'h8000_0000;

  logic clk;
  logic reset;
  logic StallF, StallD, StallE, StallM;
  logic FlushD, FlushE, FlushM;
  logic PCSrcE, RetM, TrapM, IllegalBaseInstrFaultD;
  xlenT PCTargetE, PrivilegedNextPCM;
  xlenT PCF, PCD, PCE, PCLinkE, PCM, InstrMisalignedAdrM;
  instrT InstrInF, InstrD, InstrE, InstrM;
  instrClassT InstrClassM;
  logic IllegalIEUInstrFaultD, InstrMisalignedFaultM;

  // 2 KB of halfwords, the address wraps on bit 10
  logic [15:0] mem [0:1023];
  logic [9:0]  fetchIdx;
  logic [31:0] lcgState;
  int          errorCount;

  // combinational read of the two halfwords at PCF
  assign fetchIdx = PCF[10:1];
  assign InstrInF = {mem[fetchIdx + 10'd1], mem[fetchIdx]};

  ifu dut0 (.*);

  always #(ClkPeriod / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // addi rd, rs1, imm
  function automatic instrT addiWord(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic instrT memWord(xlenT addr);
    logic [9:0] idx;
    idx = addr[10:1];
    return {mem[idx + 10'd1], mem[idx]};
  endfunction

  task automatic putWord(xlenT addr, instrT word);
    logic [9:0] idx;
    idx = addr[10:1];
    mem[idx] = word[15:0];
    mem[idx + 10'd1] = word[31:16];
  endtask

  task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED at %0t: %s got 0x%08h expected 0x%08h", $time, name, actual, expected);
    end
  endtask

  // inputs change 1 ns after the edge, outputs are read at the falling edge
  task automatic toDrivePoint();
    @(posedge clk);
    #1;
  endtask

  task automatic toSamplePoint();
    @(negedge clk);
  endtask

  // random addi x0 words everywhere, immediate mixed with the word address
  task automatic fillMemory();
    logic [31:0] rnd;
    for (int i = 0; i < 512; i++) begin
      rnd = nextRandom();
      putWord(ExpResetPc + 32'(i * 4), addiWord(5'd0, 5'd0, rnd[31:20] ^ i[11:0]));
    end
  endtask

  // mixed 32/16-bit code at the reset vector
  task automatic loadFetchProgram();
    instrT split;
    split = addiWord(5'd3, 5'd2, 12'h001);
    putWord(ExpResetPc + 32'h00, addiWord(5'd1, 5'd0, 12'h123));
    putWord(ExpResetPc + 32'h04, 32'h147d_4515);
    putWord(ExpResetPc + 32'h08, addiWord(5'd2, 5'd1, 12'h7ff));
    // c.mv, then a 32-bit addi across the word boundary, then c.nop
    putWord(ExpResetPc + 32'h0c, {split[15:0], 16'h85b2});
    putWord(ExpResetPc + 32'h10, {16'h0001, split[31:16]});
    putWord(ExpResetPc + 32'h14, addiWord(5'd4, 5'd3, 12'h040));
  endtask

  // hold PCF one cycle while the word at PCF is written, it then sits in decode
  task automatic loadDecode(instrT raw);
    toDrivePoint();
    StallF = 1'b1;
    putWord(PCF, raw);
    toDrivePoint();
    StallF = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkResetState();
    checkValue("PCF", PCF, ExpResetPc);
    checkValue("InstrD", InstrD, ExpNop);
    checkValue("InstrE", InstrE, ExpNop);
    checkValue("InstrM", InstrM, ExpNop);
    checkValue("InstrClassM", {27'd0, InstrClassM}, 32'd0);
    checkValue("InstrMisalignedFaultM", {31'd0, InstrMisalignedFaultM}, 32'd0);
  endtask

  // pc steps by 4 for low bits 11, else by 2, later stages trail by a cycle each
  task automatic sequentialFetch();
    xlenT  pcs [0:8];
    instrT word;
    pcs[0] = ExpResetPc;
    for (int i = 1; i < 9; i++) begin
      word = memWord(pcs[i-1]);
      pcs[i] = pcs[i-1] + ((word[1:0] == 2'b11) ? 32'd4 : 32'd2);
    end
    for (int i = 0; i < 8; i++) begin
      toSamplePoint();
      checkValue("PCF", PCF, pcs[i]);
      if (i >= 1) begin
        checkValue("PCD", PCD, pcs[i-1]);
      end
      // link of the execute instruction is the address after it
      if (i >= 2) begin
        checkValue("PCE", PCE, pcs[i-2]);
        checkValue("PCLinkE", PCLinkE, pcs[i-1]);
      end
      if (i >= 3) begin
        checkValue("PCM", PCM, pcs[i-3]);
      end
      toDrivePoint();
    end
  endtask

  task automatic checkExpansion(logic [15:0] half, instrT expected, logic illegal);
    loadDecode({16'h0000, half});
    toSamplePoint();
    checkValue("InstrD", InstrD, expected);
    checkValue("IllegalIEUInstrFaultD", {31'd0, IllegalIEUInstrFaultD}, {31'd0, illegal});
  endtask

  task automatic decompression();
    instrT word;
    // hand-assembled rv32c and their 32-bit forms
    checkExpansion(16'h0001, 32'h0000_0013, 1'b0);
    checkExpansion(16'h147d, 32'hfff4_0413, 1'b0);
    checkExpansion(16'h4515, 32'h0050_0513, 1'b0);
    checkExpansion(16'h6185, 32'h0000_11b7, 1'b0);
    checkExpansion(16'h85b2, 32'h00c0_05b3, 1'b0);
    checkExpansion(16'h95b2, 32'h00c5_85b3, 1'b0);
    checkExpansion(16'ha021, 32'h0080_006f, 1'b0);
    checkExpansion(16'h3ff5, 32'hffdf_f0ef, 1'b0);
    checkExpansion(16'h8082, 32'h0000_8067, 1'b0);
    checkExpansion(16'h9282, 32'h0002_80e7, 1'b0);
    checkExpansion(16'hc019, 32'h0004_0363, 1'b0);
    checkExpansion(16'he489, 32'h0004_9563, 1'b0);
    // backward branch, beq x8, x0, -2
    checkExpansion(16'hdc7d, 32'hfe04_0fe3, 1'b0);
    checkExpansion(16'h4144, 32'h0045_2483, 1'b0);
    checkExpansion(16'hc60c, 32'h00b6_2423, 1'b0);
    // addi4spn, jr x0 and lwsp are outside the subset
    checkExpansion(16'h0000, ExpNop, 1'b1);
    checkExpansion(16'h8002, ExpNop, 1'b1);
    checkExpansion(16'h4082, ExpNop, 1'b1);
    // a bad base word is flagged from outside
    word = addiWord(5'd7, 5'd7, 12'h055);
    loadDecode(word);
    IllegalBaseInstrFaultD = 1'b1;
    toSamplePoint();
    checkValue("InstrD", InstrD, word);
    checkValue("IllegalIEUInstrFaultD", {31'd0, IllegalIEUInstrFaultD}, 32'd1);
    toDrivePoint();
    IllegalBaseInstrFaultD = 1'b0;
  endtask

  // one cycle of redirect inputs, then look at PCF
  task automatic redirectOnce(logic branch, xlenT target, logic trap, logic ret,
                              xlenT privPc, xlenT expPc, logic expFault);
    toDrivePoint();
    PCSrcE = branch;
    PCTargetE = target;
    TrapM = trap;
    RetM = ret;
    PrivilegedNextPCM = privPc;
    toDrivePoint();
    PCSrcE = 1'b0;
    TrapM = 1'b0;
    RetM = 1'b0;
    toSamplePoint();
    checkValue("PCF", PCF, expPc);
    checkValue("InstrMisalignedFaultM", {31'd0, InstrMisalignedFaultM}, {31'd0, expFault});
  endtask

  task automatic redirectPriority();
    redirectOnce(1'b1, ExpResetPc + 32'h200, 1'b0, 1'b0, '0, ExpResetPc + 32'h200, 1'b0);
    redirectOnce(1'b1, ExpResetPc + 32'h300, 1'b1, 1'b0, ExpResetPc + 32'h180,
                 ExpResetPc + 32'h180, 1'b0);
    // return target given odd, fetch still goes to the halfword
    redirectOnce(1'b1, ExpResetPc + 32'h340, 1'b0, 1'b1, ExpResetPc + 32'h1c1,
                 ExpResetPc + 32'h1c0, 1'b0);
  endtask

  task automatic misalignedTarget();
    redirectOnce(1'b1, ExpResetPc + 32'h101, 1'b0, 1'b0, '0, ExpResetPc + 32'h100, 1'b1);
    checkValue("InstrMisalignedAdrM", InstrMisalignedAdrM, ExpResetPc + 32'h101);
    toSamplePoint();
    checkValue("InstrMisalignedFaultM", {31'd0, InstrMisalignedFaultM}, 32'd0);
  endtask

  task automatic stallFlush();
    xlenT  heldPc;
    instrT heldInstr;
    instrT d1;
    instrT d2;
    instrT word;
    toDrivePoint();
    StallF = 1'b1;
    StallD = 1'b1;
    toSamplePoint();
    heldPc = PCF;
    heldInstr = InstrD;
    repeat (3) begin
      toDrivePoint();
      toSamplePoint();
      checkValue("PCF", PCF, heldPc);
      checkValue("InstrD", InstrD, heldInstr);
    end
    toDrivePoint();
    StallF = 1'b0;
    StallD = 1'b0;
    // execute and memory trail decode by one and two cycles
    d1 = '0;
    d2 = '0;
    for (int k = 0; k < 6; k++) begin
      toSamplePoint();
      if (k >= 1) begin
        checkValue("InstrE", InstrE, d1);
      end
      if (k >= 2) begin
        checkValue("InstrM", InstrM, d2);
      end
      d2 = d1;
      d1 = InstrD;
      toDrivePoint();
    end
    // flush of the execute register
    word = addiWord(5'd1, 5'd1, 12'h0a5);
    loadDecode(word);
    FlushE = 1'b1;
    toSamplePoint();
    checkValue("InstrD", InstrD, word);
    toDrivePoint();
    FlushE = 1'b0;
    toSamplePoint();
    checkValue("InstrE", InstrE, ExpNop);
    // flush of the memory register
    loadDecode(word);
    toDrivePoint();
    FlushM = 1'b1;
    toSamplePoint();
    checkValue("InstrE", InstrE, word);
    toDrivePoint();
    FlushM = 1'b0;
    toSamplePoint();
    checkValue("InstrM", InstrM, ExpNop);
  endtask

  // decode, then two edges to the memory stage
  task automatic checkClass(instrT word, logic [4:0] expClass);
    loadDecode(word);
    toDrivePoint();
    toDrivePoint();
    toSamplePoint();
    checkValue("InstrM", InstrM, word);
    checkValue("InstrClassM", {27'd0, InstrClassM}, {27'd0, expClass});
  endtask

  task automatic instrClass();
    checkClass(32'h0100_00ef, 5'b10000);
    checkClass(32'h0000_8067, 5'b01000);
    checkClass(32'h0003_0067, 5'b00100);
    checkClass(32'h0100_006f, 5'b00010);
    checkClass(32'h0004_0363, 5'b00001);
    // jalr x1 through x6 is a call only
    checkClass(32'h0003_00e7, 5'b10000);
    checkClass(addiWord(5'd1, 5'd5, 12'h3c3), 5'b00000);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // run control
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    StallF = 1'b0;
    StallD = 1'b0;
    StallE = 1'b0;
    StallM = 1'b0;
    FlushD = 1'b0;
    FlushE = 1'b0;
    FlushM = 1'b0;
    PCSrcE = 1'b0;
    RetM = 1'b0;
    TrapM = 1'b0;
    IllegalBaseInstrFaultD = 1'b0;
    PCTargetE = '0;
    PrivilegedNextPCM = '0;
    errorCount = 0;
    lcgState = 32'h84cfab45;
    fillMemory();
    loadFetchProgram();
    repeat (ResetCycles - 1) @(posedge clk);
    @(negedge clk);
    checkResetState();
    @(posedge clk);
    #1;
    reset = 1'b0;
    sequentialFetch();
    decompression();
    redirectPriority();
    misalignedTarget();
    stallFlush();
    instrClass();
    $display("errors: %0d", errorCount);
    if (errorCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("timeout: tests did not finish within %0d cycles", WatchdogCycles);
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: list.f
src/ifuPkg.sv
src/fetchStage.sv
src/decompress.sv
src/decodeStage.sv
src/executePipe.sv
src/ifu.sv
dv/ifuTb.sv

// File: run.sh
#!/bin/sh
# build the ifu testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module ifuTb -f list.f -Mdir obj_dir -o ifuSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/ifuSim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints its verdict, look for the pass line
if printf '%s\n' "$out" | grep -q "^Testbench passed$"; then
  exit 0
fi
echo "pass message not found"
exit 1
